//--- hdl/aes_gctr_cfg.svh
`ifndef AES_GCTR_CFG_SVH
`define AES_GCTR_CFG_SVH

`define AES_ROUNDS 10            // AES-128.
`define APB_AW     8

// Register map.
`define REG_STATUS 8'h00
`define REG_KEY0   8'h10
`define REG_KEY1   8'h14
`define REG_KEY2   8'h18
`define REG_KEY3   8'h1C
`define REG_IV0    8'h20
`define REG_IV1    8'h24
`define REG_IV2    8'h28
`define REG_DATA0  8'h30
`define REG_DATA1  8'h34
`define REG_DATA2  8'h38
`define REG_DATA3  8'h3C

`endif

//--- hdl/aes_pkg.sv
`include "aes_gctr_cfg.svh"

package aes_pkg;

    // Byte 0 of the AES state is the most significant byte.
    typedef union packed {
        logic [0:15][7:0] bytes;
        logic [0:3][31:0] cols;
    } aes_state_u;

    typedef logic [0:`AES_ROUNDS][127:0] aes_key_sched_t;

    function automatic logic [7:0] fn_xtime(input logic [7:0] a);
        return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
    endfunction

    function automatic logic [7:0] fn_gf_mul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] p;
        logic [7:0] x;
        p = 8'h00;
        x = a;
        for (int i = 0; i < 8; i++)
        begin
            if (b[i])
                p = p ^ x;
            x = fn_xtime(x);
        end
        return p;
    endfunction

    // Inverse in GF(2^8) then the affine map.
    function automatic logic [7:0] fn_sbox(input logic [7:0] a);
        logic [7:0] inv;
        logic [7:0] sq;
        inv = 8'h01;
        sq  = a;
        for (int k = 1; k < 8; k++)
        begin
            sq  = fn_gf_mul(sq, sq);     // a^(2^k).
            inv = fn_gf_mul(inv, sq);
        end
        return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]}
                   ^ {inv[4:0], inv[7:5]} ^ {inv[3:0], inv[7:4]} ^ 8'h63;
    endfunction

    function automatic aes_state_u fn_sub_bytes(input aes_state_u s);
        aes_state_u r;
        for (int i = 0; i < 16; i++)
            r.bytes[i] = fn_sbox(s.bytes[i]);
        return r;
    endfunction

    // Row r rotates left by r columns.
    function automatic aes_state_u fn_shift_rows(input aes_state_u s);
        aes_state_u r;
        for (int c = 0; c < 4; c++)
        begin
            for (int row = 0; row < 4; row++)
                r.bytes[4 * c + row] = s.bytes[4 * ((c + row) % 4) + row];
        end
        return r;
    endfunction

    function automatic aes_state_u fn_mix_columns(input aes_state_u s);
        aes_state_u r;
        logic [7:0] a0;
        logic [7:0] a1;
        logic [7:0] a2;
        logic [7:0] a3;
        for (int c = 0; c < 4; c++)
        begin
            {a0, a1, a2, a3} = s.cols[c];
            r.cols[c] = {fn_xtime(a0) ^ fn_xtime(a1) ^ a1 ^ a2 ^ a3,
                         a0 ^ fn_xtime(a1) ^ fn_xtime(a2) ^ a2 ^ a3,
                         a0 ^ a1 ^ fn_xtime(a2) ^ fn_xtime(a3) ^ a3,
                         fn_xtime(a0) ^ a0 ^ a1 ^ a2 ^ fn_xtime(a3)};
        end
        return r;
    endfunction

    function automatic aes_state_u fn_aes_round(
        input aes_state_u s,
        input aes_state_u rk,
        input logic       last
    );
        aes_state_u t;
        t = fn_shift_rows(fn_sub_bytes(s));
        if (!last)
            t = fn_mix_columns(t);      // Final round has no MixColumns.
        for (int c = 0; c < 4; c++)
            t.cols[c] = t.cols[c] ^ rk.cols[c];
        return t;
    endfunction

    function automatic logic [127:0] fn_inc32(input logic [127:0] cb);
        return {cb[127:32], cb[31:0] + 32'd1};
    endfunction

endpackage

//--- hdl/aes_key_expand.sv
`timescale 1ns/100ps
`include "aes_gctr_cfg.svh"

module aes_key_expand (
    input  logic                    clk,
    input  logic                    i_rst_n,
    input  logic                    i_start,
    input  logic [127:0]            i_key,
    output logic                    o_ready,
    output aes_pkg::aes_key_sched_t o_key_sched
);

    logic                    r_busy;
    logic                    r_ready;
    logic [3:0]              r_cnt;
    logic [7:0]              r_rcon;
    aes_pkg::aes_state_u     r_cur;
    aes_pkg::aes_key_sched_t r_sched;

    logic [31:0]             w_rot;
    logic [31:0]             w_sub;
    aes_pkg::aes_state_u     w_next;

    always_comb
    begin
        w_rot = {r_cur.cols[3][23:0], r_cur.cols[3][31:24]};   // RotWord.
        w_sub = {aes_pkg::fn_sbox(w_rot[31:24]), aes_pkg::fn_sbox(w_rot[23:16]),
                 aes_pkg::fn_sbox(w_rot[15:8]), aes_pkg::fn_sbox(w_rot[7:0])}
                ^ {r_rcon, 24'h000000};
        w_next.cols[0] = r_cur.cols[0] ^ w_sub;
        w_next.cols[1] = r_cur.cols[1] ^ w_next.cols[0];
        w_next.cols[2] = r_cur.cols[2] ^ w_next.cols[1];
        w_next.cols[3] = r_cur.cols[3] ^ w_next.cols[2];
    end

    always_ff @(posedge clk)
    begin
        if (!i_rst_n)
        begin
            r_busy  <= 1'b0;
            r_ready <= 1'b0;
            r_cnt   <= 4'd0;
        end
        else if (i_start)
        begin
            r_busy  <= 1'b1;
            r_ready <= 1'b0;
            r_cnt   <= 4'd1;
        end
        else if (r_busy)
        begin
            r_cnt <= r_cnt + 4'd1;
            if (r_cnt == 4'(`AES_ROUNDS))
            begin
                r_busy  <= 1'b0;
                r_ready <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (i_start)
        begin
            r_cur      <= i_key;
            r_sched[0] <= i_key;
            r_rcon     <= 8'h01;
        end
        else if (r_busy)
        begin
            r_cur          <= w_next;
            r_sched[r_cnt] <= w_next;
            r_rcon         <= aes_pkg::fn_xtime(r_rcon);
        end
    end

    assign o_ready     = r_ready;
    assign o_key_sched = r_sched;

    // Controller must hold off a new key until the schedule is done.
    a_no_restart: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_start |-> !r_busy);

endmodule

//--- hdl/aes_round_stage.sv
`timescale 1ns/100ps
`include "aes_gctr_cfg.svh"

module aes_round_stage #(
    parameter int ROUND = 1
) (
    input  logic                    clk,
    input  logic                    i_rst_n,
    input  logic                    i_valid,
    input  logic [127:0]            i_cb,
    input  logic [127:0]            i_j0,
    input  logic [127:0]            i_pt,
    input  logic                    i_first,
    input  aes_pkg::aes_key_sched_t i_key_sched,
    output logic                    o_valid,
    output logic [127:0]            o_cb,
    output logic [127:0]            o_j0,
    output logic [127:0]            o_pt,
    output logic                    o_first
);

    localparam bit FIRST = (ROUND == 1);
    localparam bit LAST  = (ROUND == `AES_ROUNDS);

    logic                r_valid;
    logic                r_first;
    logic [127:0]        r_pt;
    aes_pkg::aes_state_u r_cb;
    aes_pkg::aes_state_u r_j0;

    aes_pkg::aes_state_u w_cb_in;
    aes_pkg::aes_state_u w_j0_in;
    aes_pkg::aes_state_u w_cb_enc;

    always_ff @(posedge clk)
    begin
        if (!i_rst_n)
            r_valid <= 1'b0;
        else
            r_valid <= i_valid;
    end

    always_ff @(posedge clk)
    begin
        r_cb    <= i_cb;
        r_j0    <= i_j0;
        r_pt    <= i_pt;
        r_first <= i_first;
    end

    always_comb
    begin
        w_cb_in = r_cb;
        w_j0_in = r_j0;
        if (FIRST)
        begin
            // Initial AddRoundKey.
            w_cb_in = r_cb ^ i_key_sched[0];
            w_j0_in = r_j0 ^ i_key_sched[0];
        end
        w_cb_enc = aes_pkg::fn_aes_round(w_cb_in, i_key_sched[ROUND], LAST);
        o_j0     = aes_pkg::fn_aes_round(w_j0_in, i_key_sched[ROUND], LAST);
        o_cb     = LAST ? (w_cb_enc ^ r_pt) : w_cb_enc;   // Ciphertext out of the last round.
    end

    assign o_valid = r_valid;
    assign o_pt    = r_pt;
    assign o_first = r_first & r_valid;

    a_valid_known: assert property (@(posedge clk) disable iff (!i_rst_n)
        !$isunknown(o_valid));

endmodule

//--- hdl/gctr_apb_ctrl.sv
`timescale 1ns/100ps
`include "aes_gctr_cfg.svh"

module gctr_apb_ctrl (
    input  logic               clk,
    input  logic               i_rst_n,
    input  logic               i_psel,
    input  logic               i_penable,
    input  logic               i_pwrite,
    input  logic [`APB_AW-1:0] i_paddr,
    input  logic [31:0]        i_pwdata,
    output logic [31:0]        o_prdata,
    output logic               o_pready,
    output logic               o_pslverr,
    input  logic               i_key_ready,
    input  logic               i_ct_valid,
    output logic               o_key_start,
    output logic [127:0]       o_key,
    output logic               o_launch,
    output logic [127:0]       o_cb,
    output logic [127:0]       o_j0,
    output logic [127:0]       o_pt,
    output logic               o_first
);

    logic [127:0] r_key;
    logic [63:0]  r_iv_hi;
    logic [127:0] r_j0;
    logic [127:0] r_ctr;
    logic [127:0] r_pt;
    logic         r_key_start;
    logic         r_key_loaded;
    logic         r_iv_valid;
    logic         r_first_pend;
    logic         r_launch;
    logic         r_first;
    logic [3:0]   r_inflight;

    logic         w_acc;
    logic         w_mapped;
    logic         w_is_key;
    logic         w_is_iv;
    logic         w_is_data;
    logic [1:0]   w_idx;
    logic         w_key_busy;
    logic         w_key_ready;
    logic         w_busy;
    logic         w_err;
    logic         w_wr_ok;
    logic         w_key_done;
    logic         w_iv_done;
    logic         w_launch_req;
    logic [127:0] w_j0_new;

    always_comb
    begin
        w_mapped  = 1'b1;
        w_is_key  = 1'b0;
        w_is_iv   = 1'b0;
        w_is_data = 1'b0;
        case (i_paddr)
            `REG_STATUS: ;
            `REG_KEY0, `REG_KEY1, `REG_KEY2, `REG_KEY3: w_is_key = 1'b1;
            `REG_IV0, `REG_IV1, `REG_IV2: w_is_iv = 1'b1;
            `REG_DATA0, `REG_DATA1, `REG_DATA2, `REG_DATA3: w_is_data = 1'b1;
            default: w_mapped = 1'b0;
        endcase
    end

    assign w_acc       = i_psel & i_penable;
    assign w_idx       = i_paddr[3:2];                  // Word within a 128-bit register.
    assign w_key_ready = i_key_ready & ~r_key_start;
    assign w_busy      = (r_inflight != 4'd0);
    assign w_key_busy  = r_key_start | (r_key_loaded & ~i_key_ready) | r_launch | w_busy;

    assign w_err = ~w_mapped
                 | (i_pwrite & w_is_key & w_key_busy)
                 | (i_pwrite & w_is_data & ~(w_key_ready & r_iv_valid));

    assign w_wr_ok      = w_acc & i_pwrite & ~w_err;
    assign w_key_done   = w_wr_ok & w_is_key & (w_idx == 2'd3);
    assign w_iv_done    = w_wr_ok & w_is_iv & (w_idx == 2'd2);
    assign w_launch_req = w_wr_ok & w_is_data & (w_idx == 2'd3);
    assign w_j0_new     = {r_iv_hi, i_pwdata, 32'h0000_0001};

    always_ff @(posedge clk)
    begin
        if (w_wr_ok && w_is_key)
            r_key[(3 - w_idx) * 32 +: 32] <= i_pwdata;   // KEY0 is the top word.
        if (w_wr_ok && w_is_data)
            r_pt[(3 - w_idx) * 32 +: 32] <= i_pwdata;
        if (w_wr_ok && w_is_iv && !w_iv_done)
            r_iv_hi[(1 - w_idx[0]) * 32 +: 32] <= i_pwdata;
        if (w_iv_done)
        begin
            r_j0  <= w_j0_new;
            r_ctr <= w_j0_new;
        end
        else if (w_launch_req)
            r_ctr <= aes_pkg::fn_inc32(r_ctr);           // Counter for this block.
    end

    always_ff @(posedge clk)
    begin
        if (!i_rst_n)
        begin
            r_key_start  <= 1'b0;
            r_key_loaded <= 1'b0;
            r_iv_valid   <= 1'b0;
            r_first_pend <= 1'b0;
            r_launch     <= 1'b0;
            r_first      <= 1'b0;
            r_inflight   <= 4'd0;
        end
        else
        begin
            r_key_start <= w_key_done;
            r_launch    <= w_launch_req;
            r_first     <= w_launch_req & r_first_pend;
            if (w_key_done)
                r_key_loaded <= 1'b1;
            if (w_iv_done)
            begin
                r_iv_valid   <= 1'b1;
                r_first_pend <= 1'b1;
            end
            else if (w_launch_req)
                r_first_pend <= 1'b0;
            r_inflight <= r_inflight + {3'd0, r_launch} - {3'd0, i_ct_valid};
        end
    end

    assign o_prdata    = (w_acc && !i_pwrite && i_paddr == `REG_STATUS) ?
                         {30'd0, w_busy, w_key_ready} : 32'd0;
    assign o_pready    = 1'b1;
    assign o_pslverr   = w_acc & w_err;
    assign o_key_start = r_key_start;
    assign o_key       = r_key;
    assign o_launch    = r_launch;
    assign o_cb        = r_ctr;
    assign o_j0        = r_j0;
    assign o_pt        = r_pt;
    assign o_first     = r_first;

    a_launch_keyed: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_launch |-> i_key_ready);

    a_inflight_max: assert property (@(posedge clk) disable iff (!i_rst_n)
        r_inflight <= 4'(`AES_ROUNDS));

endmodule

//--- hdl/aes_gctr_top.sv
`timescale 1ns/100ps
`include "aes_gctr_cfg.svh"

module aes_gctr_top (
    input  logic               clk,
    input  logic               i_rst_n,
    input  logic               i_psel,
    input  logic               i_penable,
    input  logic               i_pwrite,
    input  logic [`APB_AW-1:0] i_paddr,
    input  logic [31:0]        i_pwdata,
    output logic [31:0]        o_prdata,
    output logic               o_pready,
    output logic               o_pslverr,
    output logic               o_ct_valid,
    output logic [127:0]       o_ct,
    output logic [127:0]       o_ej0,
    output logic               o_first
);

    logic                    key_start;
    logic                    key_ready;
    logic [127:0]            key;
    aes_pkg::aes_key_sched_t key_sched;

    // Index 0 is the controller, index k the output of round k.
    logic                    s_valid [0:`AES_ROUNDS];
    logic [127:0]            s_cb    [0:`AES_ROUNDS];
    logic [127:0]            s_j0    [0:`AES_ROUNDS];
    logic [127:0]            s_pt    [0:`AES_ROUNDS];
    logic                    s_first [0:`AES_ROUNDS];

    gctr_apb_ctrl u_ctrl (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_psel      (i_psel),
        .i_penable   (i_penable),
        .i_pwrite    (i_pwrite),
        .i_paddr     (i_paddr),
        .i_pwdata    (i_pwdata),
        .o_prdata    (o_prdata),
        .o_pready    (o_pready),
        .o_pslverr   (o_pslverr),
        .i_key_ready (key_ready),
        .i_ct_valid  (s_valid[`AES_ROUNDS]),
        .o_key_start (key_start),
        .o_key       (key),
        .o_launch    (s_valid[0]),
        .o_cb        (s_cb[0]),
        .o_j0        (s_j0[0]),
        .o_pt        (s_pt[0]),
        .o_first     (s_first[0])
    );

    aes_key_expand u_key_expand (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_start     (key_start),
        .i_key       (key),
        .o_ready     (key_ready),
        .o_key_sched (key_sched)
    );

    for (genvar g = 1; g <= `AES_ROUNDS; g++)
    begin : g_stage
        aes_round_stage #(.ROUND(g)) u_stage (
            .clk         (clk),
            .i_rst_n     (i_rst_n),
            .i_valid     (s_valid[g-1]),
            .i_cb        (s_cb[g-1]),
            .i_j0        (s_j0[g-1]),
            .i_pt        (s_pt[g-1]),
            .i_first     (s_first[g-1]),
            .i_key_sched (key_sched),
            .o_valid     (s_valid[g]),
            .o_cb        (s_cb[g]),
            .o_j0        (s_j0[g]),
            .o_pt        (s_pt[g]),
            .o_first     (s_first[g])
        );
    end

    assign o_ct_valid = s_valid[`AES_ROUNDS];
    assign o_ct       = s_cb[`AES_ROUNDS];
    assign o_ej0      = s_j0[`AES_ROUNDS];
    assign o_first    = s_first[`AES_ROUNDS];

endmodule

//--- tb/tb_aes_gctr.sv
`timescale 1ns/100ps
`include "aes_gctr_cfg.svh"

module tb_aes_gctr;

    logic               clk = 1'b0;
    logic               i_rst_n;
    logic               i_psel;
    logic               i_penable;
    logic               i_pwrite;
    logic [`APB_AW-1:0] i_paddr;
    logic [31:0]        i_pwdata;
    logic [31:0]        o_prdata;
    logic               o_pready;
    logic               o_pslverr;
    logic               o_ct_valid;
    logic [127:0]       o_ct;
    logic [127:0]       o_ej0;
    logic               o_first;

    // Expected results in launch order.
    aes_pkg::aes_state_u ct_q [$];
    aes_pkg::aes_state_u ej0_q [$];
    logic                first_q [$];
    int                  due_q [$];

    int          cyc = 0;
    int          acc_cyc = 0;       // Cycle of the last access phase.
    logic        mon_on = 1'b0;
    logic        first_pend = 1'b0;
    logic        iv_seen = 1'b0;
    logic [31:0] rng = 32'd23724;

    aes_gctr_top uut (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_psel     (i_psel),
        .i_penable  (i_penable),
        .i_pwrite   (i_pwrite),
        .i_paddr    (i_paddr),
        .i_pwdata   (i_pwdata),
        .o_prdata   (o_prdata),
        .o_pready   (o_pready),
        .o_pslverr  (o_pslverr),
        .o_ct_valid (o_ct_valid),
        .o_ct       (o_ct),
        .o_ej0      (o_ej0),
        .o_first    (o_first)
    );

    always #2 clk = ~clk;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_block(input string what, input aes_pkg::aes_state_u got,
                               input aes_pkg::aes_state_u exp);
        if (got !== exp)
            fail_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, what, got, exp));
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp)
            fail_run($sformatf("mismatch at %0t: %s got %b expected %b", $time, what, got, exp));
    endtask

    task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
            fail_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, what, got, exp));
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n)
        begin
            @(negedge clk);
            i_psel    = 1'b0;
            i_penable = 1'b0;
        end
    endtask

    // Setup phase on one falling edge, access phase on the next.
    task automatic write_reg(input logic [`APB_AW-1:0] addr, input logic [31:0] data,
                             input logic exp_err);
        @(negedge clk);
        i_psel    = 1'b1;
        i_penable = 1'b0;
        i_pwrite  = 1'b1;
        i_paddr   = addr;
        i_pwdata  = data;
        @(negedge clk);
        i_penable = 1'b1;
        #1;                                  // Sampled before the access edge.
        acc_cyc = cyc;
        check_bit("pready", o_pready, 1'b1);
        check_bit($sformatf("pslverr on write to %h", addr), o_pslverr, exp_err);
    endtask

    task automatic read_reg(input logic [`APB_AW-1:0] addr, output logic [31:0] data,
                            input logic exp_err);
        @(negedge clk);
        i_psel    = 1'b1;
        i_penable = 1'b0;
        i_pwrite  = 1'b0;
        i_paddr   = addr;
        @(negedge clk);
        i_penable = 1'b1;
        #1;
        data = o_prdata;
        check_bit($sformatf("pslverr on read of %h", addr), o_pslverr, exp_err);
    endtask

    task automatic load_key(input logic [127:0] key);
        logic [31:0] st;
        int          polls;
        st    = 32'd0;
        polls = 0;
        write_reg(`REG_KEY0, key[127:96], 1'b0);
        write_reg(`REG_KEY1, key[95:64], 1'b0);
        write_reg(`REG_KEY2, key[63:32], 1'b0);
        write_reg(`REG_KEY3, key[31:0], 1'b0);
        write_reg(`REG_KEY0, 32'hdead_beef, 1'b1);   // Expander still running.
        while (!st[0] && polls < 30)
        begin
            read_reg(`REG_STATUS, st, 1'b0);
            polls++;
        end
        if (!st[0])
            fail_run("key ready did not set within 30 status reads");
        check_word("status after key expansion", st, 32'h1);
        if (!iv_seen)
        begin
            // No IV yet, so data must be refused and nothing launched.
            write_reg(`REG_DATA0, 32'h0123_4567, 1'b1);
            write_reg(`REG_DATA3, 32'h89ab_cdef, 1'b1);
            idle_cycles(14);
        end
    endtask

    task automatic load_iv(input logic [95:0] iv);
        write_reg(`REG_IV0, iv[95:64], 1'b0);
        write_reg(`REG_IV1, iv[63:32], 1'b0);
        write_reg(`REG_IV2, iv[31:0], 1'b0);
        iv_seen    = 1'b1;
        first_pend = 1'b1;
    endtask

    task automatic send_block(input logic [127:0] pt, input logic [127:0] ct,
                              input logic [127:0] ej0);
        rng = xorshift32(rng);
        idle_cycles(int'(rng[1:0]));
        write_reg(`REG_DATA0, pt[127:96], 1'b0);
        write_reg(`REG_DATA1, pt[95:64], 1'b0);
        write_reg(`REG_DATA2, pt[63:32], 1'b0);
        write_reg(`REG_DATA3, pt[31:0], 1'b0);
        ct_q.push_back(ct);
        ej0_q.push_back(ej0);
        first_q.push_back(first_pend);
        due_q.push_back(acc_cyc + 11);       // Falling edge after the write plus 10.
        first_pend = 1'b0;
    endtask

    task automatic finish_group(input int blocks);
        logic [31:0] st;
        int          waited;
        waited = 0;
        if (blocks > 0)
        begin
            read_reg(`REG_STATUS, st, 1'b0);
            check_word("status with blocks in flight", st, 32'h3);
            write_reg(`REG_KEY0, 32'hdead_beef, 1'b1);
        end
        while (due_q.size() != 0 && waited < 40)
        begin
            idle_cycles(1);
            waited++;
        end
        if (due_q.size() != 0)
            fail_run("pipeline did not return all results within 40 cycles");
        read_reg(`REG_STATUS, st, 1'b0);
        check_word("status after drain", st, 32'h1);
    endtask

    // Output monitor on the falling edge.
    always @(negedge clk)
    begin
        cyc = cyc + 1;
        if (mon_on)
        begin
            if (o_ct_valid)
            begin
                if (due_q.size() == 0)
                    fail_run("ciphertext valid seen with no block in flight");
                else
                begin
                    if (cyc != due_q[0])
                        fail_run($sformatf("mismatch at %0t: result in cycle %0d, expected %0d",
                                           $time, cyc, due_q[0]));
                    check_block("ciphertext", o_ct, ct_q[0]);
                    check_block("encrypted J0", o_ej0, ej0_q[0]);
                    check_bit("o_first", o_first, first_q[0]);
                    void'(ct_q.pop_front());
                    void'(ej0_q.pop_front());
                    void'(first_q.pop_front());
                    void'(due_q.pop_front());
                end
            end
            else
            begin
                check_bit("o_first while idle", o_first, 1'b0);
                if (due_q.size() != 0 && due_q[0] <= cyc)
                    fail_run("expected result did not appear 10 cycles after launch");
            end
        end
    end

    initial
    begin
        int               fd;
        int               n;
        int               blocks;
        logic [8*8-1:0]   tag;
        logic [8*256-1:0] line;
        logic [127:0]     key_v;
        logic [95:0]      iv_v;
        logic [127:0]     pt_v;
        logic [127:0]     ct_v;
        logic [127:0]     ej0_v;
        logic [31:0]      rd;
        i_rst_n   = 1'b0;
        i_psel    = 1'b0;
        i_penable = 1'b0;
        i_pwrite  = 1'b0;
        i_paddr   = '0;
        i_pwdata  = 32'd0;
        blocks    = 0;
        pt_v      = '0;
        ej0_v     = '0;
        repeat (5) @(negedge clk);
        i_rst_n = 1'b1;
        mon_on  = 1'b1;
        check_bit("o_ct_valid after reset", o_ct_valid, 1'b0);
        check_bit("o_first after reset", o_first, 1'b0);
        read_reg(`REG_STATUS, rd, 1'b0);
        check_word("status after reset", rd, 32'h0);

        write_reg(8'h40, 32'h1111_2222, 1'b1);   // Unmapped.
        read_reg(8'h04, rd, 1'b1);
        check_word("read of unmapped address", rd, 32'h0);
        idle_cycles(12);

        fd = $fopen("tb/aes_gctr_patterns.txt", "r");
        if (fd == 0)
            fail_run("cannot open tb/aes_gctr_patterns.txt");
        while (!$feof(fd))
        begin
            tag = '0;
            n = $fscanf(fd, "%s", tag);
            if (n != 1)
                break;
            if (tag == "#")
                n = $fgets(line, fd);
            else if (tag == "key")
            begin
                n = $fscanf(fd, "%h", key_v);
                load_key(key_v);
            end
            else if (tag == "iv")
            begin
                n = $fscanf(fd, "%h", iv_v);
                load_iv(iv_v);
            end
            else if (tag == "ej0")
                n = $fscanf(fd, "%h", ej0_v);
            else if (tag == "pt")
                n = $fscanf(fd, "%h", pt_v);
            else if (tag == "ct")
            begin
                n = $fscanf(fd, "%h", ct_v);
                send_block(pt_v, ct_v, ej0_v);
                blocks++;
            end
            else if (tag == "run")
            begin
                finish_group(blocks);
                blocks = 0;
            end
            else
                fail_run("unknown line in patterns file");
        end
        $fclose(fd);
        idle_cycles(2);
        $display("NO ERRORS");
        $finish;
    end

endmodule

//--- tb/aes_gctr_patterns.txt
# key <key> | iv <96-bit IV> | ej0 <expected E(K,J0)> | pt <plaintext> | ct <expected ciphertext>
# Each ct line sends the block; run drains the pipeline and ends the group.
# GCM test case 2.
key 00000000000000000000000000000000
iv 000000000000000000000000
ej0 58e2fccefa7e3061367f1d57a4e7455a
pt 00000000000000000000000000000000
ct 0388dace60b6a392f328c2b971b2fe78
run
# GCM test case 3.
key feffe9928665731c6d6a8f9467308308
iv cafebabefacedbaddecaf888
ej0 3247184b3c4f69a44dbcd22887bbb418
pt d9313225f88406e5a55909c5aff5269a
ct 42831ec2217774244b7221b784d0d49c
pt 86a7a9531534f7da2e4c303d8a318a72
ct e3aa212f2c02a4e035c17e2329aca12e
pt 1c3c0c95956809532fcf0e2449a6b525
ct 21d514b25466931c7d8f6a5aac84aa05
pt b16aedf5aa0de657ba637b391aafd255
ct 1ba30b396a0aac973d58e091473f5985
run
# Same key, IV written again so the counter restarts.
iv cafebabefacedbaddecaf888
ej0 3247184b3c4f69a44dbcd22887bbb418
pt d9313225f88406e5a55909c5aff5269a
ct 42831ec2217774244b7221b784d0d49c
pt 86a7a9531534f7da2e4c303d8a318a72
ct e3aa212f2c02a4e035c17e2329aca12e
pt 1c3c0c95956809532fcf0e2449a6b525
ct 21d514b25466931c7d8f6a5aac84aa05
pt b16aedf5aa0de657ba637b391aafd255
ct 1ba30b396a0aac973d58e091473f5985
run

//--- all.f
+incdir+hdl
hdl/aes_pkg.sv
hdl/aes_key_expand.sv
hdl/aes_round_stage.sv
hdl/gctr_apb_ctrl.sv
hdl/aes_gctr_top.sv
tb/tb_aes_gctr.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_aes_gctr
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: sim clean

# The run passes only if the log holds the pass line.
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
